/* verilog/cache_complex_config.svh */
`ifndef CACHE_COMPLEX_CONFIG_SVH
`define CACHE_COMPLEX_CONFIG_SVH

// byte address
`define CC_ADDR_WIDTH 32

// one cache line, same width on both L1 and memory side
`define CC_LINE_BITS 128

// request queue
`define CC_QUEUE_DEPTH 4
`define CC_LG_QUEUE_DEPTH 2

`endif

/* verilog/mem_types_pkg.sv */
`default_nettype none

`include "cache_complex_config.svh"

package mem_types_pkg;

   // 4-bit opcode field as on the memory port
   typedef enum logic [3:0]
   {
      MEM_LOAD  = 4'd0,
      MEM_STORE = 4'd1
   } mem_op_t;

   typedef enum logic
   {
      SRC_L1D = 1'b0,
      SRC_L1I = 1'b1
   } req_src_t;

   typedef struct packed
   {
      logic [`CC_ADDR_WIDTH-1:0] addr;
      mem_op_t                   opcode;
      req_src_t                  src;
      logic [`CC_LINE_BITS-1:0]  store_data;  // only meaningful for stores
   } mem_req_t;

   typedef enum logic
   {
      ROUTE_IDLE = 1'b0,
      ROUTE_WAIT = 1'b1
   } router_state_t;

endpackage

`default_nettype wire

/* verilog/flush_types_pkg.sv */
`default_nettype none

package flush_types_pkg;

   typedef enum logic [2:0]
   {
      FLUSH_IDLE       = 3'd0,
      WAIT_FOR_L1D_L1I = 3'd1,
      GOT_L1D          = 3'd2,  // l1d done, waiting on l1i
      GOT_L1I          = 3'd3,  // l1i done, waiting on l1d
      FLUSH_L2         = 3'd4
   } flush_state_t;

endpackage

`default_nettype wire

/* verilog/l1_request_arbiter.sv */
`default_nettype none

module l1_request_arbiter
(
   input  wire logic                   clk,
   input  wire logic                   reset,
   input  wire logic                   l1d_req_valid,
   input  mem_types_pkg::mem_req_t     l1d_req,
   output logic                        l1d_req_ready,
   input  wire logic                   l1i_req_valid,
   input  mem_types_pkg::mem_req_t     l1i_req,
   output logic                        l1i_req_ready,
   input  wire logic                   in_flush_mode,
   output logic                        out_valid,
   output mem_types_pkg::mem_req_t     out_req,
   input  wire logic                   out_ready
);
   import mem_types_pkg::*;

   req_src_t last_winner;
   logic     grant_d;
   logic     grant_i;

   // round robin, the loser of last time goes first on a tie
   assign grant_d = l1d_req_valid && (!l1i_req_valid || last_winner == SRC_L1I);
   assign grant_i = l1i_req_valid && (!l1d_req_valid || last_winner == SRC_L1D);

   assign out_valid = !in_flush_mode && (grant_d || grant_i);
   assign out_req   = grant_d ? l1d_req : l1i_req;

   assign l1d_req_ready = out_ready && !in_flush_mode && grant_d;
   assign l1i_req_ready = out_ready && !in_flush_mode && grant_i;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         last_winner <= SRC_L1I;  // l1d gets the first tie
      end
      else if (out_valid && out_ready)
      begin
         last_winner <= grant_d ? SRC_L1D : SRC_L1I;
      end
   end

endmodule

`default_nettype wire

/* verilog/mem_request_queue.sv */
`default_nettype none

`include "cache_complex_config.svh"

module mem_request_queue
(
   input  wire logic                   clk,
   input  wire logic                   reset,
   input  wire logic                   in_valid,
   input  mem_types_pkg::mem_req_t     in_req,
   output logic                        in_ready,
   output logic                        out_valid,
   output mem_types_pkg::mem_req_t     out_req,
   input  wire logic                   out_ready
);
   import mem_types_pkg::*;

   mem_req_t                     entries [`CC_QUEUE_DEPTH];
   logic [`CC_LG_QUEUE_DEPTH-1:0] wr_ptr;
   logic [`CC_LG_QUEUE_DEPTH-1:0] rd_ptr;
   logic [`CC_LG_QUEUE_DEPTH:0]   count;
   logic [`CC_LG_QUEUE_DEPTH:0]   count_next;
   logic                          push;
   logic                          pop;

   assign push = in_valid && in_ready;
   assign pop  = out_valid && out_ready;

   assign out_valid = (count != '0);
   assign out_req   = entries[rd_ptr];

   always_comb
   begin
      count_next = count;
      if (push && !pop)
         count_next = count + 1'b1;
      else if (pop && !push)
         count_next = count - 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         in_ready <= 1'b0;  // held low through reset
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         count    <= count_next;
         in_ready <= (count_next != `CC_QUEUE_DEPTH);
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
         entries[wr_ptr] <= in_req;
   end

endmodule

`default_nettype wire

/* verilog/mem_response_router.sv */
`default_nettype none

`include "cache_complex_config.svh"

module mem_response_router
(
   input  wire logic                       clk,
   input  wire logic                       reset,
   input  wire logic                       in_valid,
   input  mem_types_pkg::mem_req_t         in_req,
   output logic                            in_ready,
   output logic                            mem_req_valid,
   output mem_types_pkg::mem_req_t         mem_req,
   input  wire logic                       mem_rsp_valid,
   input  wire logic [`CC_LINE_BITS-1:0]   mem_rsp_load_data,
   output logic                            l1d_rsp_valid,
   output logic                            l1i_rsp_valid,
   output logic [`CC_LINE_BITS-1:0]        rsp_load_data
);
   import mem_types_pkg::*;

   router_state_t state;
   mem_req_t      req_q;
   req_src_t      src_q;
   logic          accept;
   logic          rsp_here;

   assign in_ready = (state == ROUTE_IDLE);
   assign accept   = in_valid && in_ready;
   assign mem_req  = req_q;

   assign rsp_here      = mem_rsp_valid && (state == ROUTE_WAIT);
   assign l1d_rsp_valid = rsp_here && (src_q == SRC_L1D);
   assign l1i_rsp_valid = rsp_here && (src_q == SRC_L1I);
   assign rsp_load_data = mem_rsp_load_data;  // shared by both caches

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state         <= ROUTE_IDLE;
         mem_req_valid <= 1'b0;
      end
      else
      begin
         mem_req_valid <= accept;  // single-cycle pulse
         case (state)
            ROUTE_IDLE:
            begin
               if (accept)
                  state <= ROUTE_WAIT;
            end
            ROUTE_WAIT:
            begin
               if (mem_rsp_valid)
                  state <= ROUTE_IDLE;
            end
            default:
            begin
               state <= ROUTE_IDLE;
            end
         endcase
      end
   end

   // outstanding request, only one at a time
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         req_q <= in_req;
         src_q <= in_req.src;
      end
   end

endmodule

`default_nettype wire

/* verilog/flush_sequencer.sv */
`default_nettype none

module flush_sequencer
(
   input  wire logic clk,
   input  wire logic reset,
   input  wire logic flush_req_l1d,
   input  wire logic flush_req_l1i,
   input  wire logic l1d_flush_complete,
   input  wire logic l1i_flush_complete,
   input  wire logic l2_flush_complete,
   output logic      in_flush_mode,
   output logic      l2_flush_req
);
   import flush_types_pkg::*;

   flush_state_t state;
   flush_state_t state_next;
   logic         flush_next;
   logic         l2_req_next;

   always_comb
   begin
      state_next  = state;
      flush_next  = in_flush_mode;
      l2_req_next = 1'b0;
      case (state)
         FLUSH_IDLE:
         begin
            // an L1 that was not asked counts as already done
            if (flush_req_l1d && flush_req_l1i)
               state_next = WAIT_FOR_L1D_L1I;
            else if (flush_req_l1i)
               state_next = GOT_L1D;
            else if (flush_req_l1d)
               state_next = GOT_L1I;
            if (flush_req_l1d || flush_req_l1i)
               flush_next = 1'b1;
         end
         WAIT_FOR_L1D_L1I:
         begin
            if (l1d_flush_complete && l1i_flush_complete)
            begin
               state_next  = FLUSH_L2;
               l2_req_next = 1'b1;
            end
            else if (l1d_flush_complete)
               state_next = GOT_L1D;
            else if (l1i_flush_complete)
               state_next = GOT_L1I;
         end
         GOT_L1D:
         begin
            if (l1i_flush_complete)
            begin
               state_next  = FLUSH_L2;
               l2_req_next = 1'b1;
            end
         end
         GOT_L1I:
         begin
            if (l1d_flush_complete)
            begin
               state_next  = FLUSH_L2;
               l2_req_next = 1'b1;
            end
         end
         FLUSH_L2:
         begin
            if (l2_flush_complete)
            begin
               state_next = FLUSH_IDLE;
               flush_next = 1'b0;
            end
         end
         default:
         begin
            state_next = FLUSH_IDLE;
            flush_next = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state         <= FLUSH_IDLE;
         in_flush_mode <= 1'b0;
         l2_flush_req  <= 1'b0;
      end
      else
      begin
         state         <= state_next;
         in_flush_mode <= flush_next;
         l2_flush_req  <= l2_req_next;
      end
   end

endmodule

`default_nettype wire

/* verilog/cache_complex.sv */
`default_nettype none

`include "cache_complex_config.svh"

module cache_complex
(
   input  wire logic                       clk,
   input  wire logic                       reset,
   input  wire logic                       l1d_req_valid,
   input  mem_types_pkg::mem_req_t         l1d_req,
   output logic                            l1d_req_ready,
   input  wire logic                       l1i_req_valid,
   input  mem_types_pkg::mem_req_t         l1i_req,
   output logic                            l1i_req_ready,
   output logic                            mem_req_valid,
   output mem_types_pkg::mem_req_t         mem_req,
   input  wire logic                       mem_rsp_valid,
   input  wire logic [`CC_LINE_BITS-1:0]   mem_rsp_load_data,
   output logic                            l1d_rsp_valid,
   output logic                            l1i_rsp_valid,
   output logic [`CC_LINE_BITS-1:0]        rsp_load_data,
   input  wire logic                       flush_req_l1d,
   input  wire logic                       flush_req_l1i,
   input  wire logic                       l1d_flush_complete,
   input  wire logic                       l1i_flush_complete,
   input  wire logic                       l2_flush_complete,
   output logic                            in_flush_mode,
   output logic                            l2_flush_req
);

   logic                    arb_valid;
   logic                    arb_ready;
   mem_types_pkg::mem_req_t arb_req;
   logic                    head_valid;
   logic                    head_ready;
   mem_types_pkg::mem_req_t head_req;

   l1_request_arbiter arbiter_inst
   (
      .clk           (clk),
      .reset         (reset),
      .l1d_req_valid (l1d_req_valid),
      .l1d_req       (l1d_req),
      .l1d_req_ready (l1d_req_ready),
      .l1i_req_valid (l1i_req_valid),
      .l1i_req       (l1i_req),
      .l1i_req_ready (l1i_req_ready),
      .in_flush_mode (in_flush_mode),  // stalls new requests only
      .out_valid     (arb_valid),
      .out_req       (arb_req),
      .out_ready     (arb_ready)
   );

   mem_request_queue queue_inst
   (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (arb_valid),
      .in_req    (arb_req),
      .in_ready  (arb_ready),
      .out_valid (head_valid),
      .out_req   (head_req),
      .out_ready (head_ready)
   );

   mem_response_router router_inst
   (
      .clk               (clk),
      .reset             (reset),
      .in_valid          (head_valid),
      .in_req            (head_req),
      .in_ready          (head_ready),
      .mem_req_valid     (mem_req_valid),
      .mem_req           (mem_req),
      .mem_rsp_valid     (mem_rsp_valid),
      .mem_rsp_load_data (mem_rsp_load_data),
      .l1d_rsp_valid     (l1d_rsp_valid),
      .l1i_rsp_valid     (l1i_rsp_valid),
      .rsp_load_data     (rsp_load_data)
   );

   flush_sequencer flush_inst
   (
      .clk                (clk),
      .reset              (reset),
      .flush_req_l1d      (flush_req_l1d),
      .flush_req_l1i      (flush_req_l1i),
      .l1d_flush_complete (l1d_flush_complete),
      .l1i_flush_complete (l1i_flush_complete),
      .l2_flush_complete  (l2_flush_complete),
      .in_flush_mode      (in_flush_mode),
      .l2_flush_req       (l2_flush_req)
   );

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen
(
   output logic clk
);
   localparam int HALF_PERIOD = 20;

   initial
   begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

endmodule

`default_nettype wire

/* verif/cache_complex_assert.sv */
`default_nettype none

module cache_complex_assert
(
   input wire logic clk,
   input wire logic reset,
   input wire logic mem_req_valid,
   input wire logic l1d_rsp_valid,
   input wire logic l1i_rsp_valid,
   input wire logic l1d_req_ready,
   input wire logic l1i_req_ready,
   input wire logic in_flush_mode,
   input wire logic l2_flush_req
);
   logic outstanding;
   int   fail_count = 0;

   // one memory request in flight
   always_ff @(posedge clk)
   begin
      if (reset)
         outstanding <= 1'b0;
      else if (mem_req_valid)
         outstanding <= 1'b1;
      else if (l1d_rsp_valid || l1i_rsp_valid)
         outstanding <= 1'b0;
   end

   single_outstanding: assert property (@(posedge clk) disable iff (reset)
      mem_req_valid |-> !outstanding)
   else
   begin
      $error("second memory request before the response");
      fail_count++;
   end

   one_rsp_valid: assert property (@(posedge clk) disable iff (reset)
      !(l1d_rsp_valid && l1i_rsp_valid))
   else
   begin
      $error("both response valids high");
      fail_count++;
   end

   no_ready_in_flush: assert property (@(posedge clk) disable iff (reset)
      in_flush_mode |-> !(l1d_req_ready || l1i_req_ready))
   else
   begin
      $error("L1 ready high during flush mode");
      fail_count++;
   end

   l2_req_in_flush: assert property (@(posedge clk) disable iff (reset)
      l2_flush_req |-> in_flush_mode)
   else
   begin
      $error("l2_flush_req outside flush mode");
      fail_count++;
   end

endmodule

bind cache_complex cache_complex_assert assert_inst
(
   .clk           (clk),
   .reset         (reset),
   .mem_req_valid (mem_req_valid),
   .l1d_rsp_valid (l1d_rsp_valid),
   .l1i_rsp_valid (l1i_rsp_valid),
   .l1d_req_ready (l1d_req_ready),
   .l1i_req_ready (l1i_req_ready),
   .in_flush_mode (in_flush_mode),
   .l2_flush_req  (l2_flush_req)
);

`default_nettype wire

/* verif/cache_complex_tb.sv */
`default_nettype none

`include "cache_complex_config.svh"

module cache_complex_tb;
   import mem_types_pkg::*;

   localparam int          DRIVE_DELAY    = 2;
   localparam int          ACCEPT_TIMEOUT = 400;
   localparam int          DRAIN_TIMEOUT  = 1000;
   localparam int          STALL_TIMEOUT  = 300;
   localparam logic [31:0] SEED           = 32'h124a_88a4;
   localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;
   localparam logic [`CC_LINE_BITS-1:0] RSP_PATTERN = {(`CC_LINE_BITS/32){32'h3c96_a55a}};

   logic                     clk;
   logic                     reset;
   logic                     l1d_req_valid;
   mem_req_t                 l1d_req;
   logic                     l1d_req_ready;
   logic                     l1i_req_valid;
   mem_req_t                 l1i_req;
   logic                     l1i_req_ready;
   logic                     mem_req_valid;
   mem_req_t                 mem_req;
   logic                     mem_rsp_valid;
   logic [`CC_LINE_BITS-1:0] mem_rsp_load_data;
   logic                     l1d_rsp_valid;
   logic                     l1i_rsp_valid;
   logic [`CC_LINE_BITS-1:0] rsp_load_data;
   logic                     flush_req_l1d;
   logic                     flush_req_l1i;
   logic                     l1d_flush_complete;
   logic                     l1i_flush_complete;
   logic                     l2_flush_complete;
   logic                     in_flush_mode;
   logic                     l2_flush_req;

   logic [31:0] lfsr_state = SEED;
   mem_req_t    issued_q[$];  // accepted, not yet sent to memory
   mem_req_t    cur_req;
   logic        outstanding = 1'b0;
   logic        stall_mem = 1'b0;
   req_src_t    prev_src = SRC_L1D;
   logic        have_prev = 1'b0;
   int          errors = 0;
   int          accepted = 0;
   int          completed = 0;
   int          l2_pulses = 0;

   tb_clock_gen clock_gen_inst (.clk(clk));

   cache_complex cache_complex_inst (.*);

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int b = 0; b < n; b++)
      begin
         lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? LFSR_TAPS : 32'h0);
         r = {r[30:0], lfsr_state[0]};
      end
      return r;
   endfunction

   // address repeated over the line
   function automatic logic [`CC_LINE_BITS-1:0] model_data(input logic [31:0] addr);
      return {(`CC_LINE_BITS/32){addr}} ^ RSP_PATTERN;
   endfunction

   function automatic logic taken_now(input req_src_t src);
      if (src == SRC_L1D)
         return l1d_req_valid && l1d_req_ready;
      return l1i_req_valid && l1i_req_ready;
   endfunction

   task automatic report_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
      $display("[FAIL] %s got %0h expected %0h", name, got, exp);
      errors++;
   endtask

   task automatic report_problem(input string msg);
      $display("%s", msg);
      errors++;
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      assert (got === exp) else report_value(name, got, exp);
   endtask

   task automatic step();
      @(posedge clk);
      #DRIVE_DELAY;
   endtask

   task automatic drive_port(input req_src_t src, input logic valid, input mem_req_t req);
      if (src == SRC_L1D)
      begin
         l1d_req_valid = valid;
         l1d_req       = req;
      end
      else
      begin
         l1i_req_valid = valid;
         l1i_req       = req;
      end
   endtask

   // busy keeps valid high between requests
   task automatic run_requester(input req_src_t src, input int n, input logic busy);
      mem_req_t r;
      int       t;
      r = '0;
      for (int k = 0; k < n; k++)
      begin
         if (!busy)
         begin
            drive_port(src, 1'b0, r);
            repeat (rand_bits(2)) step();
         end
         r.addr   = rand_bits(26) << 6;  // line aligned
         r.src    = src;
         r.opcode = (src == SRC_L1D && rand_bits(1) == 1) ? MEM_STORE : MEM_LOAD;
         for (int w = 0; w < `CC_LINE_BITS/32; w++)
            r.store_data[w*32 +: 32] = rand_bits(32);
         drive_port(src, 1'b1, r);
         t = 0;
         @(negedge clk);
         while (!taken_now(src) && t < ACCEPT_TIMEOUT)
         begin
            @(negedge clk);
            t++;
         end
         assert (t < ACCEPT_TIMEOUT) else report_problem("a request was never accepted");
         step();
      end
      drive_port(src, 1'b0, r);
   endtask

   task automatic wait_drained();
      int t;
      t = 0;
      while ((issued_q.size() != 0 || outstanding) && t < DRAIN_TIMEOUT)
      begin
         step();
         t++;
      end
      assert (t < DRAIN_TIMEOUT) else report_problem("pending requests did not drain");
   endtask

   task automatic pulse_complete(input req_src_t which, input int l2_before);
      repeat (rand_bits(2)) step();
      assert (l2_pulses == l2_before)
         else report_problem("L2 flush requested before every L1 completed");
      if (which == SRC_L1D)
         l1d_flush_complete = 1'b1;
      else
         l1i_flush_complete = 1'b1;
      step();
      l1d_flush_complete = 1'b0;
      l1i_flush_complete = 1'b0;
   endtask

   task automatic flush_case(input logic do_d, input logic do_i, input logic d_first);
      int l2_before;
      l2_before     = l2_pulses;
      flush_req_l1d = do_d;
      flush_req_l1i = do_i;
      step();
      flush_req_l1d = 1'b0;
      flush_req_l1i = 1'b0;
      @(negedge clk);
      check_bit("in_flush_mode", in_flush_mode, 1'b1);
      step();
      if (do_d && d_first)
         pulse_complete(SRC_L1D, l2_before);
      if (do_i)
         pulse_complete(SRC_L1I, l2_before);
      if (do_d && !d_first)
         pulse_complete(SRC_L1D, l2_before);
      @(negedge clk);
      check_bit("l2_flush_req", l2_flush_req, 1'b1);
      step();
      repeat (rand_bits(2)) step();
      l2_flush_complete = 1'b1;
      @(negedge clk);
      check_bit("in_flush_mode", in_flush_mode, 1'b1);
      step();
      l2_flush_complete = 1'b0;
      @(negedge clk);
      check_bit("in_flush_mode", in_flush_mode, 1'b0);
      step();
      assert (l2_pulses == l2_before + 1)
         else report_value("l2_flush_req pulses", l2_pulses - l2_before, 1);
   endtask

   // answers 1 to 8 cycles after each request
   always
   begin : memory_model
      int          delay;
      int          t;
      logic [31:0] addr;
      @(negedge clk);
      if (mem_req_valid)
      begin
         addr  = mem_req.addr;
         delay = 1 + rand_bits(3);
         repeat (delay) step();
         t = 0;
         while (stall_mem && t < STALL_TIMEOUT)
         begin
            step();
            t++;
         end
         assert (t < STALL_TIMEOUT) else report_problem("memory stall never released");
         mem_rsp_valid     = 1'b1;
         mem_rsp_load_data = model_data(addr);
         step();
         mem_rsp_valid     = 1'b0;
      end
   end

   always @(negedge clk)
   begin : scoreboard
      mem_req_t acc;
      req_src_t who;
      logic     took;
      took = 1'b0;
      acc  = '0;
      who  = SRC_L1D;
      if (l1d_req_valid && l1d_req_ready)
      begin
         acc  = l1d_req;
         took = 1'b1;
      end
      else if (l1i_req_valid && l1i_req_ready)
      begin
         acc  = l1i_req;
         who  = SRC_L1I;
         took = 1'b1;
      end
      if (!reset)
      begin
         if (took)
         begin
            assert (!in_flush_mode) else report_problem("request accepted in flush mode");
            if (l1d_req_valid && l1i_req_valid && have_prev)  // tie goes to the other one
               assert (who != prev_src) else report_value("granted source", who, ~prev_src);
            issued_q.push_back(acc);
            accepted++;
            prev_src  = who;
            have_prev = 1'b1;
         end
         if (mem_req_valid)
         begin
            assert (issued_q.size() > 0) else report_problem("memory request from nowhere");
            if (issued_q.size() > 0)
            begin
               cur_req = issued_q.pop_front();
               assert (mem_req == cur_req) else report_value("mem_req", mem_req, cur_req);
               outstanding = 1'b1;
            end
         end
         if (mem_rsp_valid)
         begin
            assert (outstanding) else report_problem("memory response with nothing pending");
            check_bit("l1d_rsp_valid", l1d_rsp_valid, cur_req.src == SRC_L1D);
            check_bit("l1i_rsp_valid", l1i_rsp_valid, cur_req.src == SRC_L1I);
            if (cur_req.opcode == MEM_LOAD)
               assert (rsp_load_data == model_data(cur_req.addr))
                  else report_value("rsp_load_data", rsp_load_data, model_data(cur_req.addr));
            outstanding = 1'b0;
            completed++;
         end
         if (l2_flush_req)
            l2_pulses++;
      end
   end

   initial
   begin
      repeat (20000) @(posedge clk);
      $display("simulation timed out");
      $display("Done: errors found");
      $finish;
   end

   initial
   begin : main
      int base;
      int fill_wait;
      int assert_errors;
      reset              = 1'b1;
      l1d_req_valid      = 1'b0;
      l1d_req            = '0;
      l1i_req_valid      = 1'b0;
      l1i_req            = '0;
      mem_rsp_valid      = 1'b0;
      mem_rsp_load_data  = '0;
      flush_req_l1d      = 1'b0;
      flush_req_l1i      = 1'b0;
      l1d_flush_complete = 1'b0;
      l1i_flush_complete = 1'b0;
      l2_flush_complete  = 1'b0;
      repeat (8) @(posedge clk);
      #DRIVE_DELAY;
      reset = 1'b0;
      @(negedge clk);
      check_bit("mem_req_valid", mem_req_valid, 1'b0);
      check_bit("l1d_rsp_valid", l1d_rsp_valid, 1'b0);
      check_bit("l1i_rsp_valid", l1i_rsp_valid, 1'b0);
      check_bit("in_flush_mode", in_flush_mode, 1'b0);
      check_bit("l2_flush_req", l2_flush_req, 1'b0);
      step();

      // random traffic with gaps
      fork
         run_requester(SRC_L1D, 20, 1'b0);
         run_requester(SRC_L1I, 20, 1'b0);
      join
      wait_drained();

      // both always valid
      fork
         run_requester(SRC_L1D, 12, 1'b1);
         run_requester(SRC_L1I, 12, 1'b1);
      join
      wait_drained();

      // memory held, queue plus router fill up
      stall_mem = 1'b1;
      base      = accepted;
      fork
         run_requester(SRC_L1D, 6, 1'b1);
         run_requester(SRC_L1I, 6, 1'b1);
         begin
            fill_wait = 0;
            while (accepted - base < `CC_QUEUE_DEPTH + 1 && fill_wait < ACCEPT_TIMEOUT)
            begin
               step();
               fill_wait++;
            end
            assert (fill_wait < ACCEPT_TIMEOUT)
               else report_problem("requests stopped before the queue filled");
            @(negedge clk);
            check_bit("l1d_req_ready", l1d_req_ready, 1'b0);
            check_bit("l1i_req_ready", l1i_req_ready, 1'b0);
            step();
            assert (accepted - base == `CC_QUEUE_DEPTH + 1)
               else report_value("accepted while stalled", accepted - base,
                                 `CC_QUEUE_DEPTH + 1);
            stall_mem = 1'b0;
         end
      join
      wait_drained();

      flush_case(1'b1, 1'b1, 1'b1);
      fork
         flush_case(1'b1, 1'b1, 1'b0);
         run_requester(SRC_L1I, 3, 1'b1);
      join
      wait_drained();
      flush_case(1'b1, 1'b0, 1'b0);
      flush_case(1'b0, 1'b1, 1'b0);
      wait_drained();

      assert (completed == accepted) else report_value("responses", completed, accepted);
      assert_errors = cache_complex_inst.assert_inst.fail_count;
      $display("check errors: %0d, assertion errors: %0d", errors, assert_errors);
      if (errors == 0 && assert_errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire

/* cache_complex.f */
+incdir+verilog
verilog/mem_types_pkg.sv
verilog/flush_types_pkg.sv
verilog/l1_request_arbiter.sv
verilog/mem_request_queue.sv
verilog/mem_response_router.sv
verilog/flush_sequencer.sv
verilog/cache_complex.sv
verif/tb_clock_gen.sv
verif/cache_complex_assert.sv
verif/cache_complex_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the cache_complex testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing -Wno-fatal \
   --top-module cache_complex_tb \
   -f cache_complex.f \
   -o sim_cache_complex

./obj_dir/sim_cache_complex +verilator+error+limit+100000 > sim.log 2>&1
cat sim.log

if grep -q "Done: errors found" sim.log; then
   echo "simulation FAILED"
   exit 1
fi

echo "simulation passed"
